// File: compile.f
hartPkg.sv
fetchUnit.sv
regFile.sv
intExecUnit.sv
loadStoreUnit.sv
hazardUnit.sv
hartCore.sv
tbHart.sv

// File: fetchUnit.sv
// fetch stage of the hart: program counter, next-pc choice and the fetch-to-decode register
`timescale 1ns/1ps

module fetchUnit #(
  parameter logic [31:0] resetVector = 32'h0000_0000
) (
  input  logic                     clk,
  input  logic                     arstN,
  input  hartPkg::hazardS          hazard,
  input  logic                     redirectE,
  input  logic [hartPkg::xlen-1:0] targetE,
  output logic [hartPkg::xlen-1:0] pcF,
  input  hartPkg::instrT           instrF,
  output hartPkg::instrT           instrD,
  output logic [hartPkg::xlen-1:0] pcD
);

  logic [hartPkg::xlen-1:0] pcNext;

  // taken branch or jal from execute wins over sequential fetch
  assign pcNext = redirectE ? targetE : pcF + 32'd4;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pcF <= resetVector;
    end else if (!hazard.stallF) begin
      pcF <= pcNext;
    end
  end

  ////////////////////////////////////////
  // fetch to decode register
  ////////////////////////////////////////

  // flushed slots become addi x0 so decode sees a harmless word
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      instrD <= hartPkg::nopInstr;
      pcD    <= '0;
    end else if (hazard.flushD) begin
      instrD <= hartPkg::nopInstr;
      pcD    <= pcF;
    end else if (!hazard.stallD) begin
      instrD <= instrF;
      pcD    <= pcF;
    end
  end

  // reset vector and every branch target have to keep fetch on word boundaries
  pcAligned: assert property (@(posedge clk) disable iff (!arstN) pcF[1:0] == 2'b00)
    else $error("fetch pc not word aligned: %h", pcF);

endmodule

// File: hartCore.sv
// top level of the five-stage hart: wires fetch, execute, load/store and hazard units together
`timescale 1ns/1ps

module hartCore #(
  parameter logic [31:0] resetVector = 32'h0000_0000
) (
  input  logic                     clk,
  input  logic                     arstN,
  // instruction port, answered in the same cycle
  output logic [hartPkg::xlen-1:0] pcF,
  input  hartPkg::instrT           instrF,
  // data port
  output logic [hartPkg::xlen-1:0] dataAdr,
  output logic [hartPkg::xlen-1:0] dataWriteData,
  output logic                     dataRead,
  output logic                     dataWrite,
  input  logic [hartPkg::xlen-1:0] dataReadData,
  input  logic                     dataReady
);

  ////////////////////////////////////////
  // unit-to-unit signals
  ////////////////////////////////////////

  hartPkg::hazardS          hazard;
  // fetch to decode
  hartPkg::instrT           instrD;
  logic [hartPkg::xlen-1:0] pcD;
  // redirect back from execute
  logic                     redirectE;
  logic [hartPkg::xlen-1:0] targetE;
  // stage records
  hartPkg::emStageS         emM;
  hartPkg::mwStageS         mwW;
  // hazard inputs
  logic [4:0]               rs1D;
  logic [4:0]               rs2D;
  logic                     loadE;
  logic [4:0]               rdE;
  logic                     memStallM;

  // pc, next-pc mux, fetch to decode register
  fetchUnit #(.resetVector(resetVector)) fetchUnit_i (.*);

  // decoder, register file, forwarding, alu, branches
  intExecUnit intExecUnit_i (.*);

  // data port strobes and load capture
  loadStoreUnit loadStoreUnit_i (.*);

  // global stall and flush
  hazardUnit hazardUnit_i (.*);

endmodule

// File: hartPkg.sv
// shared types for the five-stage hart, taken by each unit through hartPkg:: scoped names
package hartPkg;

  // data and address width, the subset is RV32 only
  localparam int xlen = 32;

  ////////////////////////////////////////
  // instruction word
  ////////////////////////////////////////

  // major opcodes the decoder knows, anything else is a no-op
  typedef enum logic [6:0] {
    opLui    = 7'b0110111,
    opJal    = 7'b1101111,
    opBranch = 7'b1100011,
    opLoad   = 7'b0000011,
    opStore  = 7'b0100011,
    opOpImm  = 7'b0010011,
    opOp     = 7'b0110011
  } opcodeE;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcodeE     opcode;
  } rTypeS;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcodeE      opcode;
  } iTypeS;

  typedef struct packed {
    logic [6:0] immHi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] immLo;
    opcodeE     opcode;
  } sTypeS;

  // branch offset bits arrive scrambled
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10to5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4to1;
    logic       imm11;
    opcodeE     opcode;
  } bTypeS;

  // upper 20 bits, read straight for LUI and unscrambled for JAL
  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    opcodeE      opcode;
  } juTypeS;

  // one fetched word, seen through every format at once
  typedef union packed {
    rTypeS  r;
    iTypeS  i;
    sTypeS  s;
    bTypeS  b;
    juTypeS ju;
  } instrT;

  // addi x0, x0, 0
  localparam instrT nopInstr = 32'h0000_0013;

  ////////////////////////////////////////
  // control and stage registers
  ////////////////////////////////////////

  typedef enum logic [3:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluXor,
    aluSlt,
    aluSll,
    aluSrl,
    aluPassB
  } aluOpE;

  typedef struct packed {
    logic  regWrite;
    logic  memRead;
    logic  memWrite;
    logic  branch;
    logic  branchNe;
    logic  jump;
    logic  aluSrcImm;
    aluOpE aluOp;
  } ctrlS;

  // decode to execute
  typedef struct packed {
    ctrlS            ctrl;
    logic [xlen-1:0] pc;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;
    logic [xlen-1:0] rs1Val;
    logic [xlen-1:0] rs2Val;
    logic [xlen-1:0] imm;
    logic            valid;
  } deStageS;

  // execute to memory, also the load/store unit's request
  typedef struct packed {
    logic            regWrite;
    logic            memRead;
    logic            memWrite;
    logic [4:0]      rd;
    logic [xlen-1:0] aluResult;
    logic [xlen-1:0] storeData;
    logic            valid;
  } emStageS;

  // memory to writeback
  typedef struct packed {
    logic            regWrite;
    logic [4:0]      rd;
    logic [xlen-1:0] result;
    logic            valid;
  } mwStageS;

  typedef struct packed {
    logic stallF;
    logic stallD;
    logic stallE;
    logic stallM;
    logic stallW;
    logic flushD;
    logic flushE;
    logic flushM;
    logic flushW;
  } hazardS;

endpackage

// File: hazardUnit.sv
// global hazard control of the hart: stalls and flushes for every pipeline register
`timescale 1ns/1ps

module hazardUnit (
  input  logic            [4:0] rs1D,
  input  logic            [4:0] rs2D,
  input  logic                  loadE,
  input  logic            [4:0] rdE,
  input  logic                  redirectE,
  input  logic                  memStallM,
  output hartPkg::hazardS       hazard
);

  logic loadUseD;

  // load in execute whose rd feeds the word in decode
  assign loadUseD = loadE && (rdE != 5'd0) && (rdE == rs1D || rdE == rs2D);

  always_comb begin
    hazard = '0;
    if (memStallM) begin
      // data port wait freezes everything, nothing is flushed
      hazard.stallF = 1'b1;
      hazard.stallD = 1'b1;
      hazard.stallE = 1'b1;
      hazard.stallM = 1'b1;
      hazard.stallW = 1'b1;
    end else begin
      // one bubble into execute for load-use
      hazard.stallF = loadUseD;
      hazard.stallD = loadUseD;
      // redirect drops the two younger words
      hazard.flushD = redirectE;
      hazard.flushE = loadUseD || redirectE;
      // no traps here, M and W are never flushed
      hazard.flushM = 1'b0;
      hazard.flushW = 1'b0;
    end
  end

endmodule

// File: intExecUnit.sv
// integer execution unit: decode, register read, forwarding, ALU and branch resolution
`timescale 1ns/1ps

module intExecUnit (
  input  logic                     clk,
  input  logic                     arstN,
  input  hartPkg::hazardS          hazard,
  input  hartPkg::instrT           instrD,
  input  logic [hartPkg::xlen-1:0] pcD,
  input  hartPkg::mwStageS         mwW,
  output hartPkg::emStageS         emM,
  output logic                     redirectE,
  output logic [hartPkg::xlen-1:0] targetE,
  output logic [4:0]               rs1D,
  output logic [4:0]               rs2D,
  output logic                     loadE,
  output logic [4:0]               rdE
);

  hartPkg::ctrlS            ctrlD;
  logic                     legalD;
  logic [hartPkg::xlen-1:0] immD;
  logic [hartPkg::xlen-1:0] rd1D;
  logic [hartPkg::xlen-1:0] rd2D;
  hartPkg::deStageS         deD;
  hartPkg::deStageS         deE;
  logic [hartPkg::xlen-1:0] srcAE;
  logic [hartPkg::xlen-1:0] fwdBE;
  logic [hartPkg::xlen-1:0] srcBE;
  logic [hartPkg::xlen-1:0] aluE;
  hartPkg::emStageS         emE;

  ////////////////////////////////////////
  // decode
  ////////////////////////////////////////

  always_comb begin
    ctrlD  = '0;
    immD   = '0;
    legalD = 1'b0;
    case (instrD.r.opcode)
      hartPkg::opLui: begin
        legalD          = 1'b1;
        ctrlD.regWrite  = 1'b1;
        ctrlD.aluSrcImm = 1'b1;
        ctrlD.aluOp     = hartPkg::aluPassB;
        immD            = {instrD.ju.imm, 12'b0};
      end
      hartPkg::opJal: begin
        legalD         = 1'b1;
        ctrlD.regWrite = 1'b1;
        ctrlD.jump     = 1'b1;
        // imm[20|10:1|11|19:12] back into order
        immD = {{12{instrD.ju.imm[19]}}, instrD.ju.imm[7:0], instrD.ju.imm[8],
                instrD.ju.imm[18:9], 1'b0};
      end
      hartPkg::opBranch: begin
        // beq and bne only
        legalD         = (instrD.b.funct3[2:1] == 2'b00);
        ctrlD.branch   = 1'b1;
        ctrlD.branchNe = instrD.b.funct3[0];
        ctrlD.aluOp    = hartPkg::aluSub;
        immD = {{20{instrD.b.imm12}}, instrD.b.imm11, instrD.b.imm10to5,
                instrD.b.imm4to1, 1'b0};
      end
      hartPkg::opLoad: begin
        legalD          = (instrD.i.funct3 == 3'b010);
        ctrlD.regWrite  = 1'b1;
        ctrlD.memRead   = 1'b1;
        ctrlD.aluSrcImm = 1'b1;
        immD            = {{20{instrD.i.imm[11]}}, instrD.i.imm};
      end
      hartPkg::opStore: begin
        legalD          = (instrD.s.funct3 == 3'b010);
        ctrlD.memWrite  = 1'b1;
        ctrlD.aluSrcImm = 1'b1;
        immD            = {{20{instrD.s.immHi[6]}}, instrD.s.immHi, instrD.s.immLo};
      end
      hartPkg::opOpImm: begin
        legalD          = 1'b1;
        ctrlD.regWrite  = 1'b1;
        ctrlD.aluSrcImm = 1'b1;
        immD            = {{20{instrD.i.imm[11]}}, instrD.i.imm};
        case (instrD.i.funct3)
          3'b000:  ctrlD.aluOp = hartPkg::aluAdd;
          3'b010:  ctrlD.aluOp = hartPkg::aluSlt;
          3'b100:  ctrlD.aluOp = hartPkg::aluXor;
          3'b110:  ctrlD.aluOp = hartPkg::aluOr;
          3'b111:  ctrlD.aluOp = hartPkg::aluAnd;
          default: legalD = 1'b0;
        endcase
      end
      hartPkg::opOp: begin
        legalD         = 1'b1;
        ctrlD.regWrite = 1'b1;
        // funct7 picks sub, sra is not in the subset
        case ({instrD.r.funct7, instrD.r.funct3})
          {7'h00, 3'b000}: ctrlD.aluOp = hartPkg::aluAdd;
          {7'h20, 3'b000}: ctrlD.aluOp = hartPkg::aluSub;
          {7'h00, 3'b001}: ctrlD.aluOp = hartPkg::aluSll;
          {7'h00, 3'b010}: ctrlD.aluOp = hartPkg::aluSlt;
          {7'h00, 3'b100}: ctrlD.aluOp = hartPkg::aluXor;
          {7'h00, 3'b101}: ctrlD.aluOp = hartPkg::aluSrl;
          {7'h00, 3'b110}: ctrlD.aluOp = hartPkg::aluOr;
          {7'h00, 3'b111}: ctrlD.aluOp = hartPkg::aluAnd;
          default:         legalD = 1'b0;
        endcase
      end
      default: legalD = 1'b0;
    endcase
    // unsupported words run as no-ops
    if (!legalD) ctrlD = '0;
    // x0 writes dropped here, later stages never look at rd == 0
    if (instrD.r.rd == 5'd0) ctrlD.regWrite = 1'b0;
  end

  assign rs1D = instrD.r.rs1;
  assign rs2D = instrD.r.rs2;

  regFile regFile_i (
    .clk   (clk),
    .arstN (arstN),
    .rs1   (rs1D),
    .rs2   (rs2D),
    .rd1   (rd1D),
    .rd2   (rd2D),
    .we    (mwW.valid && mwW.regWrite),
    .wa    (mwW.rd),
    .wd    (mwW.result)
  );

  always_comb begin
    deD.ctrl   = ctrlD;
    deD.pc     = pcD;
    deD.rs1    = rs1D;
    deD.rs2    = rs2D;
    deD.rd     = instrD.r.rd;
    deD.rs1Val = rd1D;
    deD.rs2Val = rd2D;
    deD.imm    = immD;
    deD.valid  = legalD;
  end

  // load-use and redirects both turn this slot into a bubble
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      deE <= '0;
    end else if (hazard.flushE) begin
      deE <= '0;
    end else if (!hazard.stallE) begin
      deE <= deD;
    end
  end

  ////////////////////////////////////////
  // execute
  ////////////////////////////////////////

  // newest producer first, memory stage then writeback
  always_comb begin
    srcAE = deE.rs1Val;
    fwdBE = deE.rs2Val;
    if (emM.valid && emM.regWrite && emM.rd == deE.rs1) begin
      srcAE = emM.aluResult;
    end else if (mwW.valid && mwW.regWrite && mwW.rd == deE.rs1) begin
      srcAE = mwW.result;
    end
    if (emM.valid && emM.regWrite && emM.rd == deE.rs2) begin
      fwdBE = emM.aluResult;
    end else if (mwW.valid && mwW.regWrite && mwW.rd == deE.rs2) begin
      fwdBE = mwW.result;
    end
  end

  assign srcBE = deE.ctrl.aluSrcImm ? deE.imm : fwdBE;

  always_comb begin
    case (deE.ctrl.aluOp)
      hartPkg::aluSub:   aluE = srcAE - srcBE;
      hartPkg::aluAnd:   aluE = srcAE & srcBE;
      hartPkg::aluOr:    aluE = srcAE | srcBE;
      hartPkg::aluXor:   aluE = srcAE ^ srcBE;
      hartPkg::aluSlt:   aluE = {{(hartPkg::xlen-1){1'b0}}, $signed(srcAE) < $signed(srcBE)};
      hartPkg::aluSll:   aluE = srcAE << srcBE[4:0];
      hartPkg::aluSrl:   aluE = srcAE >> srcBE[4:0];
      hartPkg::aluPassB: aluE = srcBE;
      default:           aluE = srcAE + srcBE;
    endcase
  end

  // branches compare through the subtractor, beq on zero and bne on nonzero
  assign redirectE = deE.valid &&
                     (deE.ctrl.jump || (deE.ctrl.branch && ((aluE == '0) ^ deE.ctrl.branchNe)));
  assign targetE   = deE.pc + deE.imm;

  // hazard unit needs the load in execute
  assign loadE = deE.valid && deE.ctrl.memRead;
  assign rdE   = deE.rd;

  always_comb begin
    emE.regWrite  = deE.ctrl.regWrite;
    emE.memRead   = deE.ctrl.memRead;
    emE.memWrite  = deE.ctrl.memWrite;
    emE.rd        = deE.rd;
    // jal links pc+4
    emE.aluResult = deE.ctrl.jump ? deE.pc + 32'd4 : aluE;
    emE.storeData = fwdBE;
    emE.valid     = deE.valid;
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      emM <= '0;
    end else if (hazard.flushM) begin
      emM <= '0;
    end else if (!hazard.stallM) begin
      emM <= emE;
    end
  end

  // the instruction behind a taken branch never reaches execute
  redirectFlushes: assert property (@(posedge clk) disable iff (!arstN)
    redirectE && !hazard.stallE |=> !deE.valid)
    else $error("instruction after a redirect entered execute");

endmodule

// File: loadStoreUnit.sv
// memory stage of the hart: drives the data port and builds the writeback record
`timescale 1ns/1ps

module loadStoreUnit (
  input  logic                     clk,
  input  logic                     arstN,
  input  hartPkg::hazardS          hazard,
  input  hartPkg::emStageS         emM,
  output logic [hartPkg::xlen-1:0] dataAdr,
  output logic [hartPkg::xlen-1:0] dataWriteData,
  output logic                     dataRead,
  output logic                     dataWrite,
  input  logic [hartPkg::xlen-1:0] dataReadData,
  input  logic                     dataReady,
  output logic                     memStallM,
  output hartPkg::mwStageS         mwW
);

  hartPkg::mwStageS mwM;

  // strobes stay up while the memory-stage instruction waits
  assign dataAdr       = emM.aluResult;
  assign dataWriteData = emM.storeData;
  assign dataRead      = emM.valid && emM.memRead;
  assign dataWrite     = emM.valid && emM.memWrite;

  // access finishes at the first edge with dataReady high
  assign memStallM = (dataRead || dataWrite) && !dataReady;

  always_comb begin
    mwM.regWrite = emM.regWrite;
    mwM.rd       = emM.rd;
    mwM.result   = emM.memRead ? dataReadData : emM.aluResult;
    mwM.valid    = emM.valid;
  end

  ////////////////////////////////////////
  // memory to writeback register
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      mwW <= '0;
    end else if (hazard.flushW) begin
      mwW <= '0;
    end else if (!hazard.stallW) begin
      mwW <= mwM;
    end
  end

  // a decoded word is never both load and store
  strobesExclusive: assert property (@(posedge clk) disable iff (!arstN)
    !(dataRead && dataWrite))
    else $error("data port read and write strobes both high");

  // the whole pipe freezes, so the request must not move while waiting
  requestHolds: assert property (@(posedge clk) disable iff (!arstN)
    memStallM |=> $stable({dataAdr, dataWriteData, dataRead, dataWrite}))
    else $error("data request changed while dataReady was low");

endmodule

// File: regFile.sv
// integer register file of the hart: two reads in decode, one write from writeback
`timescale 1ns/1ps

module regFile (
  input  logic                     clk,
  input  logic                     arstN,
  input  logic [4:0]               rs1,
  input  logic [4:0]               rs2,
  output logic [hartPkg::xlen-1:0] rd1,
  output logic [hartPkg::xlen-1:0] rd2,
  input  logic                     we,
  input  logic [4:0]               wa,
  input  logic [hartPkg::xlen-1:0] wd
);

  // x0 has no storage
  logic [hartPkg::xlen-1:0] regs [1:31];

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && wa != 5'd0) begin
      regs[wa] <= wd;
    end
  end

  // writeback in the same cycle shows up on the read side
  assign rd1 = (rs1 == 5'd0) ? '0 : (we && wa == rs1) ? wd : regs[rs1];
  assign rd2 = (rs2 == 5'd0) ? '0 : (we && wa == rs2) ? wd : regs[rs2];

endmodule

// File: runSim.sh
#!/bin/sh
# build the hart testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tbHart \
  -f compile.f -o simHart || exit 1
simOut=$(./obj_dir/simHart)
echo "$simOut"
echo "$simOut" | grep -q "Simulation completed successfully" && exit 0 || exit 1

// File: tbHart.sv
// testbench for hartCore: runs a hand-assembled program from a ROM model and checks every store
`timescale 1ns/1ps

module tbHart;

  // start away from zero, the ROM repeats every 256 bytes
  localparam logic [31:0] resetVector = 32'h0000_0100;
  // about 60 instructions with up to 4 wait cycles each, plus margin
  localparam int          cycleLimit  = 2000;
  localparam logic [31:0] dataBase    = 32'h0000_1000;
  localparam logic [31:0] poison      = 32'h0000_0666;
  localparam logic [31:0] markerAdr   = 32'h0000_10fc;

  logic           clk;
  logic           arstN;
  logic [31:0]    pcF;
  hartPkg::instrT instrF;
  logic [31:0]    dataAdr;
  logic [31:0]    dataWriteData;
  logic           dataRead;
  logic           dataWrite;
  logic [31:0]    dataReadData;
  logic           dataReady;

  logic [31:0] rom [0:63];
  logic [31:0] ram [0:63];
  int          romIdx;
  logic [31:0] jalPc;
  // expected stores in program order
  string       expName [$];
  logic [31:0] expAdr [$];
  logic [31:0] expVal [$];
  int          storeIdx;
  int          errors;
  int          cycles;
  int          waitLeft;
  logic        busy;
  logic        done;
  logic        holdCheck;
  logic [97:0] heldReq;

  hartCore #(.resetVector(resetVector)) hartCore_i (.*);

  always #50 clk = ~clk;

  // instruction port answers in the same cycle
  assign instrF = rom[pcF[7:2]];

  ////////////////////////////////////////
  // instruction encoders, RV32I formats
  ////////////////////////////////////////

  function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd,
                                       input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
  endfunction

  // offset bits go out scrambled, bit 0 is implied
  function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  function automatic logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, 7'h37};
  endfunction

  task automatic put(input logic [31:0] word);
    rom[romIdx] = word;
    romIdx++;
  endtask

  task automatic addStore(input string name, input logic [31:0] adr, input logic [31:0] val);
    expName.push_back(name);
    expAdr.push_back(adr);
    expVal.push_back(val);
  endtask

  task automatic loadProgram();
    for (int i = 0; i < 64; i++) begin
      rom[i] = 32'h0000_0013;
    end
    romIdx = 0;
    // back to back alu ops, forwarding from M and W
    put(encU(20'h00001, 5'd10));
    put(encI(12'd5, 5'd0, 3'b000, 5'd1, 7'h13));
    put(encI(12'hffd, 5'd0, 3'b000, 5'd2, 7'h13));
    put(encR(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
    put(encR(7'h20, 5'd2, 5'd1, 3'b000, 5'd4));
    put(encR(7'h00, 5'd1, 5'd2, 3'b010, 5'd5));
    put(encR(7'h00, 5'd3, 5'd1, 3'b001, 5'd6));
    put(encR(7'h00, 5'd3, 5'd2, 3'b101, 5'd7));
    put(encI(12'h00f, 5'd1, 3'b100, 5'd8, 7'h13));
    put(encI(12'h100, 5'd8, 3'b110, 5'd9, 7'h13));
    put(encI(12'h10c, 5'd9, 3'b111, 5'd11, 7'h13));
    put(encI(12'h000, 5'd2, 3'b010, 5'd12, 7'h13));
    put(encR(7'h00, 5'd6, 5'd4, 3'b110, 5'd13));
    put(encR(7'h00, 5'd2, 5'd7, 3'b111, 5'd14));
    put(encR(7'h00, 5'd2, 5'd1, 3'b100, 5'd15));
    put(encU(20'habcde, 5'd16));
    put(encS(12'd0, 5'd3, 5'd10));
    put(encS(12'd4, 5'd4, 5'd10));
    put(encS(12'd8, 5'd5, 5'd10));
    put(encS(12'd12, 5'd6, 5'd10));
    put(encS(12'd16, 5'd7, 5'd10));
    put(encS(12'd20, 5'd8, 5'd10));
    put(encS(12'd24, 5'd9, 5'd10));
    put(encS(12'd28, 5'd11, 5'd10));
    put(encS(12'd32, 5'd12, 5'd10));
    put(encS(12'd36, 5'd13, 5'd10));
    put(encS(12'd40, 5'd14, 5'd10));
    put(encS(12'd44, 5'd15, 5'd10));
    put(encS(12'd48, 5'd16, 5'd10));
    // write to x0 must vanish, even with the store right behind it in M
    put(encI(12'd7, 5'd1, 3'b000, 5'd0, 7'h13));
    put(encS(12'd52, 5'd0, 5'd10));
    // load-use pair, x17 gets the sub result back
    put(encI(12'd4, 5'd10, 3'b010, 5'd17, 7'h03));
    put(encR(7'h00, 5'd1, 5'd17, 3'b000, 5'd18));
    put(encS(12'd56, 5'd18, 5'd10));
    put(encI(12'h666, 5'd0, 3'b000, 5'd20, 7'h13));
    // taken beq and bne, each skips two poison stores
    put(encB(13'd12, 5'd1, 5'd1, 3'b000));
    put(encS(12'd60, 5'd20, 5'd10));
    put(encS(12'd60, 5'd20, 5'd10));
    put(encB(13'd12, 5'd2, 5'd1, 3'b001));
    put(encS(12'd60, 5'd20, 5'd10));
    put(encS(12'd60, 5'd20, 5'd10));
    // not taken, the store behind it must run
    put(encB(13'd8, 5'd2, 5'd1, 3'b000));
    put(encS(12'd60, 5'd1, 5'd10));
    jalPc = resetVector + 32'(romIdx * 4);
    put(encJ(21'd12, 5'd21));
    put(encS(12'd64, 5'd20, 5'd10));
    put(encS(12'd64, 5'd20, 5'd10));
    put(encS(12'd64, 5'd21, 5'd10));
    // completion marker, then spin in place
    put(encI(12'h5a5, 5'd0, 3'b000, 5'd22, 7'h13));
    put(encS(12'h0fc, 5'd22, 5'd10));
    put(encJ(21'd0, 5'd0));
  endtask

  task automatic loadExpected();
    addStore("add", dataBase + 32'd0, 32'd2);
    addStore("sub", dataBase + 32'd4, 32'd8);
    addStore("slt", dataBase + 32'd8, 32'd1);
    addStore("sll", dataBase + 32'd12, 32'd20);
    addStore("srl", dataBase + 32'd16, 32'h3fff_ffff);
    addStore("xori", dataBase + 32'd20, 32'd10);
    addStore("ori", dataBase + 32'd24, 32'h0000_010a);
    addStore("andi", dataBase + 32'd28, 32'h0000_0108);
    addStore("slti", dataBase + 32'd32, 32'd1);
    addStore("or", dataBase + 32'd36, 32'h0000_001c);
    addStore("and", dataBase + 32'd40, 32'h3fff_fffd);
    addStore("xor", dataBase + 32'd44, 32'hffff_fff8);
    addStore("lui", dataBase + 32'd48, 32'habcd_e000);
    addStore("x0 write", dataBase + 32'd52, 32'd0);
    addStore("load-use", dataBase + 32'd56, 32'd13);
    addStore("branch not taken", dataBase + 32'd60, 32'd5);
    addStore("jal link", dataBase + 32'd64, jalPc + 32'd4);
    addStore("marker", markerAdr, 32'h0000_05a5);
  endtask

  task automatic checkStore(input logic [31:0] adr, input logic [31:0] val);
    assert (val != poison) else begin
      errors++;
      $display("a flushed instruction stored its poison value at %h", adr);
    end
    assert (storeIdx < expAdr.size()) else begin
      errors++;
      $display("store to %h with %h after the last expected store", adr, val);
    end
    if (storeIdx < expAdr.size()) begin
      assert (adr == expAdr[storeIdx]) else begin
        errors++;
        $display("[ERROR] %s address: expected %h, actual %h", expName[storeIdx],
                 expAdr[storeIdx], adr);
      end
      assert (val == expVal[storeIdx]) else begin
        errors++;
        $display("[ERROR] %s value: expected %h, actual %h", expName[storeIdx],
                 expVal[storeIdx], val);
      end
      storeIdx++;
    end
    if (adr == markerAdr) done = 1'b1;
    ram[adr[7:2]] = val;
  endtask

  task automatic finishRun();
    $display("stores checked %0d of %0d, errors %0d", storeIdx, expAdr.size(), errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  ////////////////////////////////////////
  // data memory model
  ////////////////////////////////////////

  // decide each access half a cycle before the edge that completes it
  always @(negedge clk) begin
    if (arstN) begin
      if (holdCheck) begin
        assert ({dataAdr, dataWriteData, dataRead, dataWrite, pcF} == heldReq) else begin
          errors++;
          $display("data request or fetch pc moved while dataReady was low");
        end
      end
      holdCheck = (dataRead || dataWrite) && !dataReady;
      heldReq   = {dataAdr, dataWriteData, dataRead, dataWrite, pcF};
      if (dataRead || dataWrite) begin
        assert (dataAdr[31:8] == dataBase[31:8] && dataAdr[1:0] == 2'b00) else begin
          errors++;
          $display("data access at %h falls outside the word-aligned RAM window", dataAdr);
        end
      end
      if (dataWrite && dataReady) checkStore(dataAdr, dataWriteData);
      if ((dataRead || dataWrite) && dataReady) busy = 1'b0;
    end
  end

  // a new access draws 0 to 3 wait cycles
  always @(posedge clk) begin
    #1;
    if (dataRead || dataWrite) begin
      if (!busy) begin
        busy     = 1'b1;
        waitLeft = int'($urandom % 4);
      end else if (waitLeft > 0) begin
        waitLeft--;
      end
      dataReady    = (waitLeft == 0);
      dataReadData = ram[dataAdr[7:2]];
    end else begin
      busy      = 1'b0;
      dataReady = 1'b1;
    end
  end

  always @(posedge clk) begin
    if (arstN) cycles++;
    if (cycles == cycleLimit) begin
      errors++;
      $display("timeout after %0d cycles without the completion marker", cycles);
      finishRun();
    end
  end

  initial begin
    void'($urandom(32'hdc2e));
    clk          = 1'b0;
    arstN        = 1'b0;
    dataReadData = '0;
    dataReady    = 1'b1;
    storeIdx     = 0;
    errors       = 0;
    cycles       = 0;
    waitLeft     = 0;
    busy         = 1'b0;
    done         = 1'b0;
    holdCheck    = 1'b0;
    heldReq      = '0;
    // fill tied to each word's byte address
    for (int i = 0; i < 64; i++) begin
      ram[i] = ~(dataBase + 32'(i * 4));
    end
    loadProgram();
    loadExpected();
    repeat (3) @(posedge clk);
    #1 arstN = 1'b1;
    // first fetch address and idle strobes straight out of reset
    assert (pcF == resetVector && !dataRead && !dataWrite) else begin
      errors++;
      $display("[ERROR] reset state: expected pc %h, actual %h, strobes %b%b",
               resetVector, pcF, dataRead, dataWrite);
    end
    wait (done);
    repeat (4) @(negedge clk);
    assert (storeIdx == expAdr.size()) else begin
      errors++;
      $display("only %0d of %0d expected stores reached memory", storeIdx, expAdr.size());
    end
    finishRun();
  end

endmodule
